// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
LINTFLAGS := --lint-only -Wall
TOP       := tb_mpu
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
hdl/mpu_pkg.sv
hdl/core_trans_if.sv
hdl/pma_lookup.sv
hdl/mpu_ctrl.sv
hdl/obi_req_gen.sv
hdl/mpu_resp_path.sv
hdl/mpu_top.sv
verification/tb_clkgen.sv
verification/mpu_checker.sv
verification/tb_mpu.sv

// ==== hdl/core_trans_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface core_trans_if;

  logic                       valid;
  logic                       ready;
  logic [mpu_pkg::ADDR_W-1:0] addr;
  logic                       we;
  logic [mpu_pkg::DATA_W-1:0] wdata;
  logic                       exec;
  logic                       atomic;

  // Transfer takes place on this cycle
  logic                       accept;

  assign accept = valid && ready;

  modport ctrl (
    input  valid, addr, we, wdata, exec, atomic, accept,
    output ready
  );

  // Request issuer only needs the payload and the transfer strobe
  modport req (
    input addr, we, wdata, accept
  );

endinterface

`default_nettype wire

// ==== hdl/mpu_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpu_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  core_trans_if.ctrl           trans,
  input  logic                 fault_i,
  input  mpu_pkg::mpu_status_e status_i,
  input  logic                 req_busy_i,
  input  logic                 obi_gnt_i,
  input  logic                 obi_rvalid_i,
  output logic                 accept_ok_o,
  output logic                 err_valid_o,
  output mpu_pkg::mpu_status_e err_status_o
);

  mpu_pkg::mpu_state_e       state_q;
  mpu_pkg::mpu_state_e       state_d;
  mpu_pkg::mpu_status_e      status_q;
  logic [mpu_pkg::CNT_W-1:0] cnt_q;
  logic [mpu_pkg::CNT_W-1:0] cnt_d;
  logic                      cnt_inc;
  logic                      fault_accept;
  logic                      busy_d;
  logic                      ready_q;
  logic                      ready_d;

  assign accept_ok_o  = trans.accept && !fault_i;
  assign fault_accept = trans.accept && fault_i;
  assign cnt_inc      = req_busy_i && obi_gnt_i;

  // Outstanding count goes up on grant and down on rvalid
  always_comb begin
    cnt_d = cnt_q;
    if (cnt_inc && !obi_rvalid_i) begin
      cnt_d = cnt_q + mpu_pkg::CNT_W'(1);
    end else if (!cnt_inc && obi_rvalid_i) begin
      cnt_d = cnt_q - mpu_pkg::CNT_W'(1);
    end
  end

  ////////////////////////////////////////
  // Error sequencing
  ////////////////////////////////////////

  // Errors wait for the bus to drain so responses stay in order
  always_comb begin
    state_d = state_q;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        if (fault_accept) begin
          state_d = (cnt_d != '0) ? mpu_pkg::MPU_ERR_WAIT : mpu_pkg::MPU_ERR_RESP;
        end
      end
      mpu_pkg::MPU_ERR_WAIT: begin
        if (cnt_d == '0) begin
          state_d = mpu_pkg::MPU_ERR_RESP;
        end
      end
      default: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  // Ready is registered, so it looks at next-cycle conditions
  assign busy_d  = (req_busy_i && !obi_gnt_i) || accept_ok_o;
  assign ready_d = (state_d == mpu_pkg::MPU_IDLE) && !busy_d &&
                   (cnt_d < mpu_pkg::CNT_W'(mpu_pkg::MAX_OUTSTANDING));

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= mpu_pkg::MPU_IDLE;
      cnt_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      ready_q <= ready_d;
    end
  end

  always_ff @(posedge clk) begin
    if (fault_accept) begin
      status_q <= status_i;
    end
  end

  assign trans.ready  = ready_q;
  assign err_valid_o  = (state_q == mpu_pkg::MPU_ERR_RESP);
  assign err_status_o = status_q;

endmodule

`default_nettype wire

// ==== hdl/mpu_pkg.sv ====
`default_nettype none

package mpu_pkg;

  ////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int WORD_ADDR_W = ADDR_W - 2;
  localparam int MEMTYPE_W   = 2;

  // Granted bus transactions still waiting for rvalid
  localparam int MAX_OUTSTANDING = 2;
  localparam int CNT_W           = $clog2(MAX_OUTSTANDING + 1);

  ////////////////////////////////////////
  // Region attributes
  ////////////////////////////////////////

  // Bounds are word addresses, low inclusive and high exclusive
  typedef struct packed {
    logic [WORD_ADDR_W-1:0] word_addr_low;
    logic [WORD_ADDR_W-1:0] word_addr_high;
    logic                   main;
    logic                   bufferable;
    logic                   cacheable;
    logic                   atomic;
  } pma_region_t;

  localparam int PMA_NUM_REGIONS = 3;

  // Unmatched space is I/O with no attributes
  localparam pma_region_t PMA_R_DEFAULT = '{
    word_addr_low: '0, word_addr_high: '0,
    main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0
  };

  // Lowest index wins where regions overlap
  localparam pma_region_t PMA_CFG [PMA_NUM_REGIONS] = '{
    '{word_addr_low:  WORD_ADDR_W'(32'h0000_0000 >> 2),
      word_addr_high: WORD_ADDR_W'(32'h0001_0000 >> 2),
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, atomic: 1'b1},
    '{word_addr_low:  WORD_ADDR_W'(32'h0000_8000 >> 2),
      word_addr_high: WORD_ADDR_W'(32'h0002_0000 >> 2),
      main: 1'b0, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0},
    '{word_addr_low:  WORD_ADDR_W'(32'h1000_0000 >> 2),
      word_addr_high: WORD_ADDR_W'(32'h1000_1000 >> 2),
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0}
  };

  ////////////////////////////////////////
  // Control and status encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    MPU_IDLE,
    MPU_ERR_WAIT,
    MPU_ERR_RESP
  } mpu_state_e;

  typedef enum logic [1:0] {
    MPU_OK,
    MPU_RE_FAULT,
    MPU_WR_FAULT
  } mpu_status_e;

endpackage

`default_nettype wire

// ==== hdl/mpu_resp_path.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpu_resp_path (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       obi_rvalid_i,
  input  logic [mpu_pkg::DATA_W-1:0] obi_rdata_i,
  input  logic                       err_valid_i,
  input  mpu_pkg::mpu_status_e       err_status_i,
  output logic                       core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0] core_resp_rdata_o,
  output mpu_pkg::mpu_status_e       core_resp_status_o
);

  logic                       valid_q;
  logic [mpu_pkg::DATA_W-1:0] rdata_q;
  mpu_pkg::mpu_status_e       status_q;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= obi_rvalid_i || err_valid_i;
    end
  end

  // Bus data and error never arrive together since errors wait for drain
  always_ff @(posedge clk) begin
    if (obi_rvalid_i) begin
      rdata_q  <= obi_rdata_i;
      status_q <= mpu_pkg::MPU_OK;
    end else if (err_valid_i) begin
      rdata_q  <= '0;
      status_q <= err_status_i;
    end
  end

  assign core_resp_valid_o  = valid_q;
  assign core_resp_rdata_o  = rdata_q;
  assign core_resp_status_o = status_q;

endmodule

`default_nettype wire

// ==== hdl/mpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpu_top (
  input  logic                          clk,
  input  logic                          rst_n,

  // Core request
  input  logic                          core_valid_i,
  output logic                          core_ready_o,
  input  logic [mpu_pkg::ADDR_W-1:0]    core_addr_i,
  input  logic                          core_we_i,
  input  logic [mpu_pkg::DATA_W-1:0]    core_wdata_i,
  input  logic                          core_exec_i,
  input  logic                          core_atomic_i,

  // Core response
  output logic                          core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0]    core_resp_rdata_o,
  output mpu_pkg::mpu_status_e          core_resp_status_o,

  // OBI
  output logic                          obi_req_o,
  input  logic                          obi_gnt_i,
  output logic [mpu_pkg::ADDR_W-1:0]    obi_addr_o,
  output logic                          obi_we_o,
  output logic [mpu_pkg::DATA_W-1:0]    obi_wdata_o,
  output logic [mpu_pkg::MEMTYPE_W-1:0] obi_memtype_o,
  input  logic                          obi_rvalid_i,
  input  logic [mpu_pkg::DATA_W-1:0]    obi_rdata_i
);

  mpu_pkg::pma_region_t region;
  mpu_pkg::mpu_status_e pma_status;
  mpu_pkg::mpu_status_e err_status;
  logic                 pma_fault;
  logic                 accept_ok;
  logic                 req_busy;
  logic                 err_valid;

  core_trans_if trans ();

  assign trans.valid  = core_valid_i;
  assign trans.addr   = core_addr_i;
  assign trans.we     = core_we_i;
  assign trans.wdata  = core_wdata_i;
  assign trans.exec   = core_exec_i;
  assign trans.atomic = core_atomic_i;
  assign core_ready_o = trans.ready;

  ////////////////////////////////////////
  // Lookup and control
  ////////////////////////////////////////

  pma_lookup u_pma_lookup (
    .addr_i   (trans.addr),
    .exec_i   (trans.exec),
    .atomic_i (trans.atomic),
    .we_i     (trans.we),
    .region_o (region),
    .fault_o  (pma_fault),
    .status_o (pma_status)
  );

  mpu_ctrl u_mpu_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .trans        (trans),
    .fault_i      (pma_fault),
    .status_i     (pma_status),
    .req_busy_i   (req_busy),
    .obi_gnt_i    (obi_gnt_i),
    .obi_rvalid_i (obi_rvalid_i),
    .accept_ok_o  (accept_ok),
    .err_valid_o  (err_valid),
    .err_status_o (err_status)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  obi_req_gen u_obi_req_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans         (trans),
    .accept_ok_i   (accept_ok),
    .region_i      (region),
    .obi_gnt_i     (obi_gnt_i),
    .busy_o        (req_busy),
    .obi_req_o     (obi_req_o),
    .obi_addr_o    (obi_addr_o),
    .obi_we_o      (obi_we_o),
    .obi_wdata_o   (obi_wdata_o),
    .obi_memtype_o (obi_memtype_o)
  );

  mpu_resp_path u_mpu_resp_path (
    .clk                (clk),
    .rst_n              (rst_n),
    .obi_rvalid_i       (obi_rvalid_i),
    .obi_rdata_i        (obi_rdata_i),
    .err_valid_i        (err_valid),
    .err_status_i       (err_status),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rdata_o  (core_resp_rdata_o),
    .core_resp_status_o (core_resp_status_o)
  );

endmodule

`default_nettype wire

// ==== hdl/obi_req_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module obi_req_gen (
  input  logic                          clk,
  input  logic                          rst_n,
  core_trans_if.req                     trans,
  input  logic                          accept_ok_i,
  input  mpu_pkg::pma_region_t          region_i,
  input  logic                          obi_gnt_i,
  output logic                          busy_o,
  output logic                          obi_req_o,
  output logic [mpu_pkg::ADDR_W-1:0]    obi_addr_o,
  output logic                          obi_we_o,
  output logic [mpu_pkg::DATA_W-1:0]    obi_wdata_o,
  output logic [mpu_pkg::MEMTYPE_W-1:0] obi_memtype_o
);

  logic                          req_q;
  logic [mpu_pkg::ADDR_W-1:0]    addr_q;
  logic                          we_q;
  logic [mpu_pkg::DATA_W-1:0]    wdata_q;
  logic [mpu_pkg::MEMTYPE_W-1:0] memtype_q;

  // Request stays up until the grant is seen
  always_ff @(posedge clk) begin
    if (rst_n) begin
      req_q <= 1'b0;
    end else if (accept_ok_i) begin
      req_q <= 1'b1;
    end else if (req_q && obi_gnt_i) begin
      req_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Request fields
  ////////////////////////////////////////

  // Core is held off while a request is pending, so fields stay stable
  always_ff @(posedge clk) begin
    if (trans.accept) begin
      addr_q    <= trans.addr;
      we_q      <= trans.we;
      wdata_q   <= trans.wdata;
      memtype_q <= {region_i.cacheable, region_i.bufferable};
    end
  end

  assign busy_o        = req_q;
  assign obi_req_o     = req_q;
  assign obi_addr_o    = addr_q;
  assign obi_we_o      = we_q;
  assign obi_wdata_o   = wdata_q;
  assign obi_memtype_o = memtype_q;

endmodule

`default_nettype wire

// ==== hdl/pma_lookup.sv ====
`timescale 1ns/1ns
`default_nettype none

module pma_lookup (
  input  logic [mpu_pkg::ADDR_W-1:0] addr_i,
  input  logic                       exec_i,
  input  logic                       atomic_i,
  input  logic                       we_i,
  output mpu_pkg::pma_region_t       region_o,
  output logic                       fault_o,
  output mpu_pkg::mpu_status_e       status_o
);

  logic [mpu_pkg::WORD_ADDR_W-1:0] word_addr;
  logic                            found;

  assign word_addr = addr_i[mpu_pkg::ADDR_W-1:2];

  // First region in index order that contains the address
  always_comb begin
    region_o = mpu_pkg::PMA_R_DEFAULT;
    found    = 1'b0;
    for (int i = 0; i < mpu_pkg::PMA_NUM_REGIONS; i++) begin
      if (!found &&
          (word_addr >= mpu_pkg::PMA_CFG[i].word_addr_low) &&
          (word_addr <  mpu_pkg::PMA_CFG[i].word_addr_high)) begin
        region_o = mpu_pkg::PMA_CFG[i];
        found    = 1'b1;
      end
    end
  end

  // Fetch needs main memory, atomics need atomic support
  assign fault_o = (exec_i && !region_o.main) || (atomic_i && !region_o.atomic);

  always_comb begin
    if (!fault_o) begin
      status_o = mpu_pkg::MPU_OK;
    end else if (we_i) begin
      status_o = mpu_pkg::MPU_WR_FAULT;
    end else begin
      status_o = mpu_pkg::MPU_RE_FAULT;
    end
  end

endmodule

`default_nettype wire

// ==== verification/mpu_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpu_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          core_valid_i,
  input  logic                          core_ready_i,
  input  logic [mpu_pkg::ADDR_W-1:0]    core_addr_i,
  input  logic                          core_we_i,
  input  logic [mpu_pkg::DATA_W-1:0]    core_wdata_i,
  input  logic                          core_exec_i,
  input  logic                          core_atomic_i,
  input  logic                          resp_valid_i,
  input  logic [mpu_pkg::DATA_W-1:0]    resp_rdata_i,
  input  mpu_pkg::mpu_status_e          resp_status_i,
  input  logic                          obi_req_i,
  input  logic                          obi_gnt_i,
  input  logic [mpu_pkg::ADDR_W-1:0]    obi_addr_i,
  input  logic                          obi_we_i,
  input  logic [mpu_pkg::DATA_W-1:0]    obi_wdata_i,
  input  logic [mpu_pkg::MEMTYPE_W-1:0] obi_memtype_i,
  input  logic                          obi_rvalid_i,
  input  logic [mpu_pkg::DATA_W-1:0]    obi_rdata_i,
  output logic                          fail_o,
  output logic                          idle_o
);

  typedef struct packed {
    logic [mpu_pkg::ADDR_W-1:0]    addr;
    logic                          we;
    logic [mpu_pkg::DATA_W-1:0]    wdata;
    logic [mpu_pkg::MEMTYPE_W-1:0] memtype;
  } bus_req_t;

  bus_req_t                   req_exp_q[$];
  logic                       resp_is_bus_q[$];
  mpu_pkg::mpu_status_e       resp_status_q[$];
  logic [mpu_pkg::DATA_W-1:0] rdata_q[$];
  int                         outstanding = 0;
  int                         pending = 0;
  int                         errors = 0;
  logic                       in_reset_q = 1'b0;
  logic                       req_wait_q = 1'b0;

  assign fail_o = (errors != 0);
  assign idle_o = (pending == 0) && (outstanding == 0);

  task automatic report_error(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // Scan from the top so that the lowest matching index is kept
  function automatic mpu_pkg::pma_region_t find_region(input logic [mpu_pkg::ADDR_W-1:0] addr);
    mpu_pkg::pma_region_t r;
    r = mpu_pkg::PMA_R_DEFAULT;
    for (int i = mpu_pkg::PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (addr[31:2] >= mpu_pkg::PMA_CFG[i].word_addr_low &&
          addr[31:2] <  mpu_pkg::PMA_CFG[i].word_addr_high) begin
        r = mpu_pkg::PMA_CFG[i];
      end
    end
    return r;
  endfunction

  always @(posedge clk) begin
    mpu_pkg::pma_region_t       region;
    mpu_pkg::mpu_status_e       status;
    bus_req_t                   exp;
    logic                       fault;
    logic                       is_bus;
    logic [mpu_pkg::DATA_W-1:0] data;

    if (in_reset_q) begin
      assert (!obi_req_i && !core_ready_i && !resp_valid_i)
        else report_error("outputs not low after a reset edge");
    end
    in_reset_q = rst_n;

    if (rst_n) begin
      req_exp_q.delete();
      resp_is_bus_q.delete();
      resp_status_q.delete();
      rdata_q.delete();
      outstanding = 0;
      req_wait_q  = 1'b0;
    end else begin
      ////////////////////////////////////////
      // Bus occupancy
      ////////////////////////////////////////
      assert (outstanding <= mpu_pkg::MAX_OUTSTANDING)
        else report_error("too many bus transactions in flight");
      if (outstanding == mpu_pkg::MAX_OUTSTANDING) begin
        assert (!core_ready_i) else report_error("core ready high with the bus full");
      end

      // Responses come back in accept order
      if (resp_valid_i) begin
        assert (resp_status_q.size() > 0) else report_error("core response with none pending");
        if (resp_status_q.size() > 0) begin
          status = resp_status_q.pop_front();
          is_bus = resp_is_bus_q.pop_front();
          data   = '0;
          if (is_bus) begin
            assert (rdata_q.size() > 0)
              else report_error("bus response before any rvalid from the bus");
            if (rdata_q.size() > 0) begin
              data = rdata_q.pop_front();
            end
          end
          assert (resp_status_i == status)
            else report_error($sformatf("status %s, expected %s",
                                        resp_status_i.name(), status.name()));
          assert (resp_rdata_i == data)
            else report_error($sformatf("rdata %h, expected %h", resp_rdata_i, data));
        end
      end

      ////////////////////////////////////////
      // Bus request
      ////////////////////////////////////////
      if (req_wait_q) begin
        assert (obi_req_i) else report_error("obi_req dropped before grant");
      end
      if (obi_req_i) begin
        assert (req_exp_q.size() > 0) else report_error("bus request with no allowed access");
        if (req_exp_q.size() > 0) begin
          exp = req_exp_q[0];
          assert (obi_addr_i == exp.addr && obi_we_i == exp.we && obi_wdata_i == exp.wdata)
            else report_error($sformatf("bus addr %h we %b, expected addr %h we %b",
                                        obi_addr_i, obi_we_i, exp.addr, exp.we));
          assert (obi_memtype_i == exp.memtype)
            else report_error($sformatf("memtype %b, expected %b", obi_memtype_i, exp.memtype));
          if (obi_gnt_i) begin
            void'(req_exp_q.pop_front());
          end
        end
        if (obi_gnt_i) begin
          outstanding++;
        end
      end
      req_wait_q = obi_req_i && !obi_gnt_i;

      if (obi_rvalid_i) begin
        rdata_q.push_back(obi_rdata_i);
        outstanding--;
      end

      // Expected outcome of each accepted transfer
      if (core_valid_i && core_ready_i) begin
        region = find_region(core_addr_i);
        fault  = (core_exec_i && !region.main) || (core_atomic_i && !region.atomic);
        if (!fault) begin
          status = mpu_pkg::MPU_OK;
        end else if (core_we_i) begin
          status = mpu_pkg::MPU_WR_FAULT;
        end else begin
          status = mpu_pkg::MPU_RE_FAULT;
        end
        resp_is_bus_q.push_back(!fault);
        resp_status_q.push_back(status);
        if (!fault) begin
          exp.addr    = core_addr_i;
          exp.we      = core_we_i;
          exp.wdata   = core_wdata_i;
          exp.memtype = {region.cacheable, region.bufferable};
          req_exp_q.push_back(exp);
        end
      end
    end
    pending = resp_status_q.size() + req_exp_q.size();
  end

endmodule

`default_nettype wire

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int PERIOD_NS  = 8;
  localparam int RST_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset is active high and released on a rising edge
  initial begin
    rst_n = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verification/tb_mpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mpu;

  localparam int SEED        = 60005;
  localparam int NUM_RANDOM  = 40;
  localparam int NUM_FIXED   = 18;
  localparam int CYCLE_LIMIT = 200 * (NUM_RANDOM + NUM_FIXED);

  logic                          clk;
  logic                          rst_n;
  logic                          core_valid_i;
  logic                          core_ready_o;
  logic [mpu_pkg::ADDR_W-1:0]    core_addr_i;
  logic                          core_we_i;
  logic [mpu_pkg::DATA_W-1:0]    core_wdata_i;
  logic                          core_exec_i;
  logic                          core_atomic_i;
  logic                          core_resp_valid_o;
  logic [mpu_pkg::DATA_W-1:0]    core_resp_rdata_o;
  mpu_pkg::mpu_status_e          core_resp_status_o;
  logic                          obi_req_o;
  logic                          obi_gnt_i = 1'b0;
  logic [mpu_pkg::ADDR_W-1:0]    obi_addr_o;
  logic                          obi_we_o;
  logic [mpu_pkg::DATA_W-1:0]    obi_wdata_o;
  logic [mpu_pkg::MEMTYPE_W-1:0] obi_memtype_o;
  logic                          obi_rvalid_i = 1'b0;
  logic [mpu_pkg::DATA_W-1:0]    obi_rdata_i = '0;

  logic                          fail_seen;
  logic                          checker_idle;
  logic                          slow_bus = 1'b0;
  int                            cycles = 0;
  int                            gnt_dly = -1;
  logic [mpu_pkg::DATA_W-1:0]    slave_data_q[$];
  int                            slave_dly_q[$];

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mpu_top u_mpu_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_valid_i       (core_valid_i),
    .core_ready_o       (core_ready_o),
    .core_addr_i        (core_addr_i),
    .core_we_i          (core_we_i),
    .core_wdata_i       (core_wdata_i),
    .core_exec_i        (core_exec_i),
    .core_atomic_i      (core_atomic_i),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_rdata_o  (core_resp_rdata_o),
    .core_resp_status_o (core_resp_status_o),
    .obi_req_o          (obi_req_o),
    .obi_gnt_i          (obi_gnt_i),
    .obi_addr_o         (obi_addr_o),
    .obi_we_o           (obi_we_o),
    .obi_wdata_o        (obi_wdata_o),
    .obi_memtype_o      (obi_memtype_o),
    .obi_rvalid_i       (obi_rvalid_i),
    .obi_rdata_i        (obi_rdata_i)
  );

  mpu_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_valid_i  (core_valid_i),
    .core_ready_i  (core_ready_o),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_wdata_i  (core_wdata_i),
    .core_exec_i   (core_exec_i),
    .core_atomic_i (core_atomic_i),
    .resp_valid_i  (core_resp_valid_o),
    .resp_rdata_i  (core_resp_rdata_o),
    .resp_status_i (core_resp_status_o),
    .obi_req_i     (obi_req_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_addr_i    (obi_addr_o),
    .obi_we_i      (obi_we_o),
    .obi_wdata_i   (obi_wdata_o),
    .obi_memtype_i (obi_memtype_o),
    .obi_rvalid_i  (obi_rvalid_i),
    .obi_rdata_i   (obi_rdata_i),
    .fail_o        (fail_seen),
    .idle_o        (checker_idle)
  );

  ////////////////////////////////////////
  // Bus slave model
  ////////////////////////////////////////

  // Grant after 0 to 3 cycles, rvalid 0 to 3 cycles after grant, in order
  always @(posedge clk) begin
    if (rst_n) begin
      obi_gnt_i    <= 1'b0;
      obi_rvalid_i <= 1'b0;
      gnt_dly = -1;
      slave_data_q.delete();
      slave_dly_q.delete();
    end else begin
      if (obi_req_o && obi_gnt_i) begin
        obi_gnt_i <= 1'b0;
        gnt_dly = -1;
        slave_data_q.push_back($urandom);
        slave_dly_q.push_back(slow_bus ? 3 : $urandom_range(3, 0));
      end else if (obi_req_o) begin
        if (gnt_dly < 0) begin
          gnt_dly = slow_bus ? 0 : $urandom_range(3, 0);
        end
        if (gnt_dly == 0) begin
          obi_gnt_i <= 1'b1;
        end else begin
          gnt_dly--;
        end
      end
      obi_rvalid_i <= 1'b0;
      if (slave_dly_q.size() > 0) begin
        if (slave_dly_q[0] == 0) begin
          obi_rvalid_i <= 1'b1;
          obi_rdata_i  <= slave_data_q.pop_front();
          void'(slave_dly_q.pop_front());
        end else begin
          slave_dly_q[0] = slave_dly_q[0] - 1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Hold the transfer until it is accepted
  task automatic send(input logic [31:0] addr, input logic we, input logic exec,
                      input logic atomic);
    core_valid_i  <= 1'b1;
    core_addr_i   <= addr;
    core_we_i     <= we;
    core_wdata_i  <= $urandom;
    core_exec_i   <= exec;
    core_atomic_i <= atomic;
    @(posedge clk);
    while (!core_ready_o) @(posedge clk);
    core_valid_i <= 1'b0;
  endtask

  // Classes: region 0 only, overlap, region 1 only, region 2, unmatched
  function automatic logic [31:0] pick_addr(input int unsigned sel, input logic [31:0] r);
    logic [31:0] a;
    case (sel)
      0:       a = 32'h0000_0000 | (r & 32'h0000_7ffc);
      1:       a = 32'h0000_8000 | (r & 32'h0000_7ffc);
      2:       a = 32'h0001_0000 | (r & 32'h0000_fffc);
      3:       a = 32'h1000_0000 | (r & 32'h0000_0ffc);
      default: a = 32'h2000_0000 | (r & 32'h00ff_fffc);
    endcase
    return a;
  endfunction

  initial begin
    int unsigned sel;
    logic        exec;
    logic        atomic;
    logic        we;

    void'($urandom(SEED));
    core_valid_i  = 1'b0;
    core_addr_i   = '0;
    core_we_i     = 1'b0;
    core_wdata_i  = '0;
    core_exec_i   = 1'b0;
    core_atomic_i = 1'b0;
    @(posedge clk);
    while (rst_n) @(posedge clk);

    // Region edges and the overlap
    send(32'h0000_0100, 1'b0, 1'b0, 1'b0);
    send(32'h0000_8000, 1'b1, 1'b0, 1'b0);
    send(32'h0000_fffc, 1'b0, 1'b0, 1'b0);
    send(32'h0001_0000, 1'b0, 1'b0, 1'b0);
    send(32'h0001_fffc, 1'b1, 1'b0, 1'b0);
    send(32'h1000_0000, 1'b0, 1'b0, 1'b0);
    send(32'h1000_1000, 1'b0, 1'b0, 1'b0);
    send(32'h0000_0200, 1'b0, 1'b1, 1'b0);
    send(32'h0000_9000, 1'b1, 1'b0, 1'b1);

    // Faults with an idle bus
    send(32'h0001_0000, 1'b0, 1'b1, 1'b0);
    send(32'h0001_4000, 1'b1, 1'b0, 1'b1);
    send(32'h1000_0800, 1'b0, 1'b1, 1'b0);
    send(32'h3000_0000, 1'b0, 1'b1, 1'b0);
    send(32'h2000_0000, 1'b0, 1'b0, 1'b1);

    // Slow responses fill the bus, then a fault queues behind them
    slow_bus <= 1'b1;
    send(32'h0000_0040, 1'b0, 1'b0, 1'b0);
    send(32'h0001_0040, 1'b0, 1'b0, 1'b0);
    send(32'h1000_0040, 1'b0, 1'b1, 1'b0);
    send(32'h0000_0080, 1'b0, 1'b0, 1'b0);
    slow_bus <= 1'b0;

    for (int i = 0; i < NUM_RANDOM; i++) begin
      sel      = $urandom_range(4, 0);
      exec     = ($urandom_range(3, 0) == 0);
      atomic   = !exec && ($urandom_range(3, 0) == 0);
      we       = !exec && ($urandom_range(1, 0) == 1);
      slow_bus <= ($urandom_range(3, 0) == 0);
      repeat ($urandom_range(2, 0)) @(posedge clk);
      send(pick_addr(sel, $urandom), we, exec, atomic);
    end

    repeat (2) @(posedge clk);
    while (!checker_idle) @(posedge clk);
    repeat (2) @(posedge clk);

    if (!fail_seen && checker_idle && !obi_req_o) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "Transactions left unfinished at the end of the run");
    end
  end

  ////////////////////////////////////////
  // Failure and timeout
  ////////////////////////////////////////

  always @(posedge fail_seen) begin
    $display("Simulation FAILED");
    $fatal(1, "Stopping on the first checker error");
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Simulation FAILED");
      $fatal(1, "Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

endmodule

`default_nettype wire
